/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_bch
FILELIST  = bch.f
OBJ_DIR   = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

/* bch.f */
source/bch_pkg.sv
source/bch_control.sv
source/syndrome.sv
source/ibm.sv
source/chien_search.sv
source/output_selector.sv
source/bch.sv
tests/tb_clock.sv
tests/tb_bch.sv

/* source/bch.sv */
`default_nettype none

module bch (
	input  logic                       i_clk,
	input  logic                       i_arst_n,
	input  logic                       i_set,    // beat 0 rides with the set cycle
	input  logic [bch_pkg::BEAT_W-1:0] i_data,   // beats 1..15 on the following cycles
	output logic                       o_ready,
	output logic                       o_finish,
	output bch_pkg::loc_t              o_data
);

	logic                          beat_wen;
	logic                          beat_first;
	logic                          word_done;
	bch_pkg::gf_t                  s1;
	bch_pkg::gf_t                  s3;
	logic                          syn_valid;
	bch_pkg::gf_t                  lambda0;
	bch_pkg::gf_t                  lambda1;
	bch_pkg::gf_t                  lambda2;
	bch_pkg::deg_t                 degree;
	logic                          loc_ok;
	logic                          loc_valid;
	logic                          root_hit;
	logic [bch_pkg::CHIEN_PAR-1:0] root_mask;
	bch_pkg::loc_t                 base_loc;
	logic                          search_done;
	logic                          search_ok;

	//==========================================================================
	// control and syndrome
	//==========================================================================
	bch_control u_control (
		.i_clk(i_clk),                 // 1 bit
		.i_arst_n(i_arst_n),           // 1 bit
		.i_set(i_set),                 // 1 bit
		.i_word_done(word_done),       // 1 bit
		.o_ready(o_ready),             // 1 bit
		.o_beat_wen(beat_wen),         // 1 bit
		.o_beat_first(beat_first)      // 1 bit
	);

	syndrome u_syndrome (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_beat_wen(beat_wen),
		.i_beat_first(beat_first),
		.i_data(i_data),               // 64 bits
		.o_s1(s1),                     // 10 bits
		.o_s3(s3),                     // 10 bits
		.o_valid(syn_valid)
	);

	//==========================================================================
	// locator and root search
	//==========================================================================
	ibm u_ibm (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_s1(s1),
		.i_s3(s3),
		.i_valid(syn_valid),
		.o_lambda0(lambda0),           // 10 bits
		.o_lambda1(lambda1),           // 10 bits
		.o_lambda2(lambda2),           // 10 bits
		.o_degree(degree),             // 2 bits
		.o_ok(loc_ok),
		.o_valid(loc_valid)
	);

	chien_search u_chien_search (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_lambda0(lambda0),
		.i_lambda1(lambda1),
		.i_lambda2(lambda2),
		.i_degree(degree),
		.i_ok(loc_ok),
		.i_valid(loc_valid),
		.o_root_hit(root_hit),
		.o_root_mask(root_mask),       // 4 bits
		.o_base_loc(base_loc),         // 10 bits
		.o_done(search_done),
		.o_ok(search_ok)
	);

	output_selector u_output_selector (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_root_hit(root_hit),
		.i_root_mask(root_mask),
		.i_base_loc(base_loc),
		.i_done(search_done),
		.i_ok(search_ok),
		.o_data(o_data),               // 10 bits
		.o_finish(o_finish),
		.o_word_done(word_done)
	);

endmodule

`default_nettype wire

/* source/bch_control.sv */
`default_nettype none

module bch_control (
	input  logic i_clk,
	input  logic i_arst_n,
	input  logic i_set,        // start strobe
	input  logic i_word_done,  // end marker leaves the decoder
	output logic o_ready,
	output logic o_beat_wen,
	output logic o_beat_first
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_BUSY
	} state_t;

	state_t state;
	logic [$clog2(bch_pkg::BEATS)-1:0] beat_cnt;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state    <= ST_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_set) begin  // set outside idle is dropped
						state    <= ST_LOAD;
						beat_cnt <= '0;
					end
				end
				ST_LOAD: begin
					beat_cnt <= beat_cnt + 1'b1;
					if (&beat_cnt)  // sixteenth beat
						state <= ST_BUSY;
				end
				ST_BUSY: begin
					if (i_word_done)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign o_ready      = (state == ST_IDLE);
	assign o_beat_wen   = (state == ST_LOAD);
	assign o_beat_first = (state == ST_LOAD) && (beat_cnt == '0);  // clears syndrome

	// the output stage only finishes words this FSM started
	a_done_not_idle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_word_done |-> (state != ST_IDLE));

endmodule

`default_nettype wire

/* source/bch_pkg.sv */
`default_nettype none

package bch_pkg;

	//==========================================================================
	// code and field constants
	//==========================================================================
	localparam int GF_M      = 10;    // GF(2^10)
	localparam int CODE_N    = 1023;  // 2^GF_M - 1
	localparam int BEAT_W    = 64;    // input bits per beat
	localparam int BEATS     = 16;    // beats per received word
	localparam int CHIEN_PAR = 4;     // root search lanes
	localparam int T_MAX     = 2;     // correctable errors

	typedef logic [GF_M-1:0]            gf_t;   // field element, polynomial basis
	typedef logic [GF_M-1:0]            loc_t;  // codeword position
	typedef logic [$clog2(T_MAX+1)-1:0] deg_t;  // locator degree 0..T_MAX

	localparam loc_t END_LOC    = loc_t'(CODE_N);          // end marker, unused position
	localparam gf_t  GF_POLY_LO = gf_t'(10'b00_0000_1001); // x^10 = x^3 + 1

	//==========================================================================
	// field arithmetic
	//==========================================================================

	// times alpha, one reduction step
	function automatic gf_t gf_xtime(input gf_t a);
		return {a[GF_M-2:0], 1'b0} ^ (a[GF_M-1] ? GF_POLY_LO : gf_t'(0));
	endfunction

	function automatic gf_t gf_mul(input gf_t a, input gf_t b);
		gf_t acc;
		gf_t sh;
		acc = '0;
		sh  = a;
		for (int i = 0; i < GF_M; i++) begin
			if (b[i])
				acc = acc ^ sh;  // shift-and-add
			sh = gf_xtime(sh);
		end
		return acc;
	endfunction

	// alpha^e for constant exponents, negative e wraps mod CODE_N
	function automatic gf_t gf_alpha_pow(input int e);
		gf_t r;
		int  n;
		r = gf_t'(1);
		n = e % CODE_N;
		if (n < 0)
			n = n + CODE_N;
		for (int i = 0; i < n; i++)
			r = gf_xtime(r);
		return r;
	endfunction

endpackage

`default_nettype wire

/* source/chien_search.sv */
`default_nettype none

module chien_search (
	input  logic                          i_clk,
	input  logic                          i_arst_n,
	input  bch_pkg::gf_t                  i_lambda0,
	input  bch_pkg::gf_t                  i_lambda1,
	input  bch_pkg::gf_t                  i_lambda2,
	input  bch_pkg::deg_t                 i_degree,
	input  logic                          i_ok,
	input  logic                          i_valid,
	output logic                          o_root_hit,
	output logic [bch_pkg::CHIEN_PAR-1:0] o_root_mask,
	output bch_pkg::loc_t                 o_base_loc,
	output logic                          o_done,
	output logic                          o_ok
);

	logic [bch_pkg::GF_M-$clog2(bch_pkg::CHIEN_PAR)-1:0] cyc;  // search cycle c
	logic                          active;
	bch_pkg::gf_t                  t0;       // lambda0
	bch_pkg::gf_t                  t1;       // lambda1 * alpha^-4c
	bch_pkg::gf_t                  t2;       // lambda2 * alpha^-8c
	bch_pkg::deg_t                 deg_q;
	logic                          ok_q;
	logic                          eval_en;
	logic [2:0]                    root_cnt;
	logic [2:0]                    hit_cnt;
	logic [bch_pkg::CHIEN_PAR-1:0] lane_hit;
	bch_pkg::gf_t                  lane_val [bch_pkg::CHIEN_PAR];

	assign o_base_loc = {cyc, {$clog2(bch_pkg::CHIEN_PAR){1'b0}}};
	assign eval_en    = active && ok_q && (deg_q != '0);  // zero locator has no roots

	//==========================================================================
	// lanes, lambda(alpha^-(4c+i))
	//==========================================================================
	for (genvar i = 0; i < bch_pkg::CHIEN_PAR; i++) begin : g_lane
		assign lane_val[i] = t0
			^ bch_pkg::gf_mul(t1, bch_pkg::gf_alpha_pow(-i))
			^ bch_pkg::gf_mul(t2, bch_pkg::gf_alpha_pow(-2 * i));
		assign lane_hit[i] = eval_en && (lane_val[i] == '0)
			&& ((o_base_loc + bch_pkg::loc_t'(i)) != bch_pkg::END_LOC);  // 1023 aliases 0
	end

	assign hit_cnt     = 3'($countones(lane_hit));
	assign o_root_hit  = |lane_hit;
	assign o_root_mask = lane_hit;
	assign o_done      = active && (&cyc);
	assign o_ok        = ok_q && ((root_cnt + hit_cnt) == {1'b0, deg_q});

	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			t0    <= i_lambda0;
			t1    <= i_lambda1;
			t2    <= i_lambda2;
			deg_q <= i_degree;
			ok_q  <= i_ok;
		end else if (active) begin
			t1 <= bch_pkg::gf_mul(t1, bch_pkg::gf_alpha_pow(-bch_pkg::CHIEN_PAR));
			t2 <= bch_pkg::gf_mul(t2, bch_pkg::gf_alpha_pow(-2 * bch_pkg::CHIEN_PAR));
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			active   <= 1'b0;
			cyc      <= '0;
			root_cnt <= '0;
		end else if (i_valid) begin
			active   <= 1'b1;
			cyc      <= '0;
			root_cnt <= '0;
		end else if (active) begin
			cyc      <= cyc + 1'b1;
			root_cnt <= root_cnt + hit_cnt;
			if (&cyc)
				active <= 1'b0;  // 256 cycles done
		end
	end

	// a locator from ibm has degree two at most
	a_two_roots: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		$countones(lane_hit) <= bch_pkg::T_MAX);

endmodule

`default_nettype wire

/* source/ibm.sv */
`default_nettype none

module ibm (
	input  logic          i_clk,
	input  logic          i_arst_n,
	input  bch_pkg::gf_t  i_s1,
	input  bch_pkg::gf_t  i_s3,
	input  logic          i_valid,
	output bch_pkg::gf_t  o_lambda0,
	output bch_pkg::gf_t  o_lambda1,
	output bch_pkg::gf_t  o_lambda2,
	output bch_pkg::deg_t o_degree,
	output logic          o_ok,
	output logic          o_valid
);

	bch_pkg::gf_t  s1_sq_n;
	bch_pkg::gf_t  s1_q;
	bch_pkg::gf_t  s3_q;
	bch_pkg::gf_t  s1_sq;   // S1^2
	bch_pkg::gf_t  s1_cu;   // S1^3
	bch_pkg::gf_t  lam2_n;
	bch_pkg::deg_t degree_n;
	logic          s1_zero;
	logic          step1;

	assign s1_sq_n = bch_pkg::gf_mul(i_s1, i_s1);

	// step one, powers of S1
	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			s1_q  <= i_s1;
			s3_q  <= i_s3;
			s1_sq <= s1_sq_n;
			s1_cu <= bch_pkg::gf_mul(s1_sq_n, i_s1);
		end
	end

	// locator scaled by S1: S1 + S1^2 x + (S3 + S1^3) x^2
	assign lam2_n  = s3_q ^ s1_cu;
	assign s1_zero = (s1_q == '0);

	always_comb begin
		if (s1_zero && (s3_q == '0))
			degree_n = bch_pkg::deg_t'(0);  // clean word
		else if (!s1_zero && (lam2_n == '0))
			degree_n = bch_pkg::deg_t'(1);  // S3 == S1^3
		else
			degree_n = bch_pkg::deg_t'(2);
	end

	// step two
	always_ff @(posedge i_clk) begin
		if (step1) begin
			o_lambda0 <= s1_q;
			o_lambda1 <= s1_sq;
			o_lambda2 <= lam2_n;
			o_degree  <= degree_n;
			o_ok      <= !(s1_zero && (s3_q != '0));  // more than two errors
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			step1   <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			step1   <= i_valid;
			o_valid <= step1;
		end
	end

	// step one registers must hold until step two has read them
	a_no_overlap: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		step1 |-> !i_valid);

endmodule

`default_nettype wire

/* source/output_selector.sv */
`default_nettype none

module output_selector (
	input  logic                          i_clk,
	input  logic                          i_arst_n,
	input  logic                          i_root_hit,
	input  logic [bch_pkg::CHIEN_PAR-1:0] i_root_mask,
	input  bch_pkg::loc_t                 i_base_loc,
	input  logic                          i_done,
	input  logic                          i_ok,
	output bch_pkg::loc_t                 o_data,
	output logic                          o_finish,
	output logic                          o_word_done
);

	bch_pkg::loc_t loc_buf [bch_pkg::T_MAX];  // ascending, search order
	bch_pkg::loc_t buf_n   [bch_pkg::T_MAX];
	logic [1:0]    wr_cnt;
	logic [1:0]    cnt_n;
	logic [1:0]    n_emit;    // positions to report
	logic [1:0]    rd_idx;
	logic          emitting;

	always_comb begin
		buf_n = loc_buf;
		cnt_n = wr_cnt;
		if (i_root_hit) begin
			for (int i = 0; i < bch_pkg::CHIEN_PAR; i++) begin
				if (i_root_mask[i] && (cnt_n != 2'(bch_pkg::T_MAX))) begin  // low lane first
					buf_n[cnt_n[0]] = i_base_loc + bch_pkg::loc_t'(i);
					cnt_n           = cnt_n + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		loc_buf <= buf_n;
	end

	//==========================================================================
	// emission, positions then end marker
	//==========================================================================
	assign o_finish    = emitting;
	assign o_data      = (rd_idx < n_emit) ? loc_buf[rd_idx[0]] : bch_pkg::END_LOC;
	assign o_word_done = emitting && (rd_idx == n_emit);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_cnt   <= '0;
			n_emit   <= '0;
			rd_idx   <= '0;
			emitting <= 1'b0;
		end else begin
			wr_cnt <= o_word_done ? '0 : cnt_n;
			if (i_done) begin
				emitting <= 1'b1;
				rd_idx   <= '0;
				n_emit   <= i_ok ? cnt_n : '0;  // uncorrectable, marker only
			end else if (o_word_done) begin
				emitting <= 1'b0;
			end else if (emitting) begin
				rd_idx <= rd_idx + 1'b1;
			end
		end
	end

	// the search never finds more roots than the locator degree allows
	a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_root_hit |-> (int'(wr_cnt) + $countones(i_root_mask)) <= bch_pkg::T_MAX);

endmodule

`default_nettype wire

/* source/syndrome.sv */
`default_nettype none

module syndrome (
	input  logic                       i_clk,
	input  logic                       i_arst_n,
	input  logic                       i_beat_wen,
	input  logic                       i_beat_first,
	input  logic [bch_pkg::BEAT_W-1:0] i_data,
	output bch_pkg::gf_t               o_s1,
	output bch_pkg::gf_t               o_s3,
	output logic                       o_valid
);

	logic [bch_pkg::BEAT_W-1:0]         data_q;  // input register
	logic [bch_pkg::BEAT_W-1:0]         data_m;
	logic [$clog2(bch_pkg::BEATS)-1:0]  beat_cnt;
	logic [$clog2(bch_pkg::BEATS)-1:0]  beat_idx;
	logic                               last_beat;
	bch_pkg::gf_t                       term1 [bch_pkg::BEAT_W];
	bch_pkg::gf_t                       term3 [bch_pkg::BEAT_W];
	bch_pkg::gf_t                       sum1;
	bch_pkg::gf_t                       sum3;
	bch_pkg::gf_t                       pw1;      // alpha^(64k)
	bch_pkg::gf_t                       pw3;      // alpha^(192k)
	bch_pkg::gf_t                       pw1_cur;
	bch_pkg::gf_t                       pw3_cur;
	bch_pkg::gf_t                       s1_acc;
	bch_pkg::gf_t                       s3_acc;

	always_ff @(posedge i_clk) begin
		data_q <= i_data;
	end

	assign beat_idx  = i_beat_first ? '0 : beat_cnt;
	assign last_beat = &beat_idx;
	assign data_m    = last_beat ? {1'b0, data_q[bch_pkg::BEAT_W-2:0]} : data_q;  // drop pos 1023

	//==========================================================================
	// beat sums over the set bits
	//==========================================================================
	for (genvar j = 0; j < bch_pkg::BEAT_W; j++) begin : g_bit
		assign term1[j] = data_m[j] ? bch_pkg::gf_alpha_pow(j) : '0;
		assign term3[j] = data_m[j] ? bch_pkg::gf_alpha_pow(3 * j) : '0;
	end

	always_comb begin
		sum1 = '0;
		sum3 = '0;
		for (int j = 0; j < bch_pkg::BEAT_W; j++) begin
			sum1 = sum1 ^ term1[j];
			sum3 = sum3 ^ term3[j];
		end
	end

	//==========================================================================
	// accumulation
	//==========================================================================
	assign pw1_cur = i_beat_first ? bch_pkg::gf_t'(1) : pw1;
	assign pw3_cur = i_beat_first ? bch_pkg::gf_t'(1) : pw3;

	always_ff @(posedge i_clk) begin
		if (i_beat_wen) begin
			s1_acc <= (i_beat_first ? '0 : s1_acc) ^ bch_pkg::gf_mul(sum1, pw1_cur);
			s3_acc <= (i_beat_first ? '0 : s3_acc) ^ bch_pkg::gf_mul(sum3, pw3_cur);
			pw1    <= bch_pkg::gf_mul(pw1_cur, bch_pkg::gf_alpha_pow(bch_pkg::BEAT_W));
			pw3    <= bch_pkg::gf_mul(pw3_cur, bch_pkg::gf_alpha_pow(3 * bch_pkg::BEAT_W));
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			beat_cnt <= '0;
			o_valid  <= 1'b0;
		end else begin
			if (i_beat_wen)
				beat_cnt <= beat_idx + 1'b1;
			o_valid <= i_beat_wen && last_beat;  // one cycle after beat 15
		end
	end

	assign o_s1 = s1_acc;
	assign o_s3 = s3_acc;

endmodule

`default_nettype wire

/* tests/bch_patterns.txt */
// base (0 zero word, 1 all ones), error count, position a, position b
// unused positions are 000, a base of fff ends the list
0 0 000 000
1 0 000 000
0 1 000 000
1 1 3fe 000
0 1 155 000
0 2 005 02a
1 2 3fe 000
0 2 040 07f
1 2 3c0 3fd
0 2 001 002
1 2 200 1ff
fff fff fff fff

/* tests/tb_bch.sv */
`default_nettype none

module tb_bch;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DRIVE_DLY   = 2;    // ns after the rising edge
	localparam int RST_CYCLES  = 16;
	localparam int CASE_CYCLES = 300;  // budget per decoded word
	localparam int N_RAND      = 24;
	localparam int MAX_DIR     = 64;

	logic                       clk;
	logic                       arst_n;
	logic                       set;
	logic [bch_pkg::BEAT_W-1:0] data_in;
	logic                       ready;
	logic                       finish;
	bch_pkg::loc_t              loc_out;

	logic [11:0] pat_mem [0:4*MAX_DIR-1];  // base, count, pos a, pos b
	logic [15:0] lfsr;
	int          err_cnt;
	int          chk_cnt;
	int          cycle_cnt;
	int          cycle_limit;

	tb_clock #(.HALF_NS(20), .RST_CYCLES(RST_CYCLES)) u_clock (
		.o_clk(clk),
		.o_arst_n(arst_n)
	);

	bch uut (
		.i_clk(clk),
		.i_arst_n(arst_n),
		.i_set(set),
		.i_data(data_in),
		.o_ready(ready),
		.o_finish(finish),
		.o_data(loc_out)
	);

	//==========================================================================
	// helpers
	//==========================================================================
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		chk_cnt++;
		if (expected !== actual) begin
			err_cnt++;
			$display("FAIL %s expected 0x%0h got 0x%0h", name, expected, actual);
		end
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val  = (val << 1) | int'(lfsr[0]);  // one step per bit
		end
	endtask

	task automatic step_cycle();
		@(posedge clk);
		#(DRIVE_DLY);
	endtask

	task automatic run_case(input int base, input int n_err, input int pos_a, input int pos_b);
		logic [1023:0] word;
		int            got_pos [$];
		int            exp_lo;
		int            exp_hi;
		int            wait_cnt;
		logic          seen_end;
		word = (base != 0) ? '1 : '0;  // both bases are codewords
		if (n_err > 0)
			word[10'(pos_a)] = ~word[10'(pos_a)];
		if (n_err > 1)
			word[10'(pos_b)] = ~word[10'(pos_b)];
		exp_lo = (n_err == 2 && pos_b < pos_a) ? pos_b : pos_a;
		exp_hi = (n_err == 2 && pos_b < pos_a) ? pos_a : pos_b;
		while (!ready)
			step_cycle();
		set     = 1'b1;
		data_in = word[63:0];  // beat 0 with the set
		for (int k = 1; k < bch_pkg::BEATS; k++) begin
			step_cycle();
			set     = 1'b0;
			data_in = word[64*k +: 64];
			check_value("o_ready", 32'(0), 32'(ready));
		end
		step_cycle();
		data_in  = '0;
		seen_end = 1'b0;
		wait_cnt = 0;
		while (!seen_end) begin
			check_value("o_ready", 32'(0), 32'(ready));
			if (finish) begin
				if (loc_out == bch_pkg::END_LOC)
					seen_end = 1'b1;
				else
					got_pos.push_back(int'(loc_out));
			end
			if (!seen_end) begin
				step_cycle();
				set = (wait_cnt == 3);  // stray set while busy
				wait_cnt++;
			end
		end
		step_cycle();
		set = 1'b0;
		check_value("o_ready", 32'(1), 32'(ready));  // back up after marker
		check_value("position count", 32'(n_err), 32'(got_pos.size()));
		if (n_err > 0 && got_pos.size() > 0)
			check_value("o_data", 32'(exp_lo), 32'(got_pos[0]));
		if (n_err > 1 && got_pos.size() > 1)
			check_value("o_data", 32'(exp_hi), 32'(got_pos[1]));
	endtask

	//==========================================================================
	// timeout
	//==========================================================================
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout after %0d cycles, decoder never finished", cycle_cnt);
			$display("sim failed");
			$finish;
		end
	end

	//==========================================================================
	// main sequence
	//==========================================================================
	initial begin
		int n_dir;
		int base;
		int n_err;
		int pos_a;
		int pos_b;
		set       = 1'b0;
		data_in   = '0;
		lfsr      = 16'd91;
		err_cnt   = 0;
		chk_cnt   = 0;
		cycle_cnt = 0;
		$readmemh("tests/bch_patterns.txt", pat_mem);
		n_dir = 0;
		while (n_dir < MAX_DIR && pat_mem[4*n_dir] != 12'hfff)
			n_dir++;
		cycle_limit = (n_dir + N_RAND) * CASE_CYCLES + RST_CYCLES;

		while (!arst_n)
			step_cycle();
		repeat (4) begin  // idle after reset
			check_value("o_ready", 32'(1), 32'(ready));
			check_value("o_finish", 32'(0), 32'(finish));
			step_cycle();
		end

		for (int c = 0; c < n_dir; c++)
			run_case(int'(pat_mem[4*c]), int'(pat_mem[4*c+1]),
				int'(pat_mem[4*c+2]), int'(pat_mem[4*c+3]));

		for (int r = 0; r < N_RAND; r++) begin
			take_bits(1, base);
			do
				take_bits(2, n_err);
			while (n_err == 3);
			do
				take_bits(10, pos_a);
			while (pos_a == 1023);
			do
				take_bits(10, pos_b);
			while (pos_b == 1023 || pos_b == pos_a);  // no duplicates
			run_case(base, n_err, pos_a, pos_b);
		end

		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`default_nettype none

module tb_clock #(
	parameter int HALF_NS    = 20,  // 40 ns period
	parameter int RST_CYCLES = 16
) (
	output logic o_clk,
	output logic o_arst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		o_clk = 1'b0;
		forever #(HALF_NS) o_clk = ~o_clk;
	end

	initial begin
		o_arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		#2 o_arst_n = 1'b1;  // release off the edge
	end

endmodule

`default_nettype wire
